/* image_fetch_golden.txt */
// words 0 to 63: image pixels in raster order, value A0rc for row r and column c
// words 64 to 191: expected beats, data then a nibble of {0, mode, line_end, pass_end}
// image
A000 A001 A002 A003 A004 A005 A006 A007
A010 A011 A012 A013 A014 A015 A016 A017
A020 A021 A022 A023 A024 A025 A026 A027
A030 A031 A032 A033 A034 A035 A036 A037
A040 A041 A042 A043 A044 A045 A046 A047
A050 A051 A052 A053 A054 A055 A056 A057
A060 A061 A062 A063 A064 A065 A066 A067
A070 A071 A072 A073 A074 A075 A076 A077
// partition 0 x scan, rows 0 to 3
A0000 A0010 A0020 A0030 A0040 A0050 A0060 A0072
A0100 A0110 A0120 A0130 A0140 A0150 A0160 A0172
A0200 A0210 A0220 A0230 A0240 A0250 A0260 A0272
A0300 A0310 A0320 A0330 A0340 A0350 A0360 A0372
// partition 0 y scan, columns 0 to 3
A0004 A0104 A0204 A0304 A0404 A0504 A0604 A0706
A0014 A0114 A0214 A0314 A0414 A0514 A0614 A0716
A0024 A0124 A0224 A0324 A0424 A0524 A0624 A0726
A0034 A0134 A0234 A0334 A0434 A0534 A0634 A0736
// partition 1 x scan, rows 4 to 7
A0400 A0410 A0420 A0430 A0440 A0450 A0460 A0472
A0500 A0510 A0520 A0530 A0540 A0550 A0560 A0572
A0600 A0610 A0620 A0630 A0640 A0650 A0660 A0672
A0700 A0710 A0720 A0730 A0740 A0750 A0760 A0772
// partition 1 y scan, columns 4 to 7, pass_end on the last beat
A0044 A0144 A0244 A0344 A0444 A0544 A0644 A0746
A0054 A0154 A0254 A0354 A0454 A0554 A0654 A0756
A0064 A0164 A0264 A0364 A0464 A0564 A0664 A0766
A0074 A0174 A0274 A0374 A0474 A0574 A0674 A0777

/* sources.f */
+incdir+.
nabp_pkg.sv
image_loader.sv
image_ram.sv
image_addresser.sv
pixel_streamer.sv
image_fetch_top.sv
tb_image_fetch.sv

/* Makefile */
TOP = tb_image_fetch

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* tb_image_fetch.sv */
`timescale 1ns/1ps
`include "nabp_config.svh"

module tb_image_fetch;

    localparam int total_beats = 2 * `NABP_PIXELS;
    localparam int golden_w = $clog2(`NABP_PIXELS + total_beats);
    localparam int wait_limit = 400;

    logic                     clk;
    logic                     reset_n;
    logic                     in_write;
    logic [`NABP_PIXEL_W-1:0] in_data;
    logic                     kick;
    logic                     enable;
    logic                     image_loaded;
    logic                     kick_ack;
    logic                     out_valid;
    nabp_pkg::pixel_out_t     out_pixel;

    // pixels, then expected beats as {data, 1'b0, mode, line_end, pass_end}
    logic [19:0] golden_mem [0:`NABP_PIXELS+total_beats-1];

    int          error_count;
    int          test_count;
    int          beat_count;
    int          enable_count;
    int          x_beats;
    int          y_beats;
    int          pass_end_beat;
    logic [31:0] lcg_state;

    image_fetch_top image_fetch_top_i (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic next_enable();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        // low about one cycle in four
        return lcg_state[17:16] != 2'b00;
    endfunction

    task automatic check(input logic ok, input string msg);
        assert (ok)
        else
        begin
            error_count++;
            $display("Fail at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        $display("Timed out waiting for %s", what);
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("test %0d %s: %s", test_count, name,
                 (error_count == errors_before) ? "ok" : "failed");
    endtask

    task automatic apply_reset();
        reset_n <= 1'b1;
        repeat (3) @(posedge clk);
        reset_n <= 1'b0;
    endtask

    task automatic load_image();
        int cycles;
        for (int i = 0; i < `NABP_PIXELS; i++)
        begin
            @(posedge clk);
            in_write <= 1'b1;
            in_data  <= golden_mem[golden_w'(i)][`NABP_PIXEL_W-1:0];
        end
        // 63 writes taken so far
        @(negedge clk);
        check(!image_loaded, "image_loaded high before the last write");
        @(posedge clk);
        in_write <= 1'b0;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (!image_loaded && cycles < 10);
        if (!image_loaded)
            report_timeout("image_loaded");
    endtask

    // ack_cycles stays 0 when no kick_ack comes within the limit
    task automatic kick_and_wait_ack(input logic enable_level, input int limit,
                                     output int ack_cycles);
        int cycles;
        @(posedge clk);
        kick          <= 1'b1;
        enable        <= enable_level;
        beat_count    = 0;
        enable_count  = 0;
        x_beats       = 0;
        y_beats       = 0;
        pass_end_beat = 0;
        @(posedge clk);
        kick <= 1'b0;
        cycles = 0;
        ack_cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (!kick_ack && cycles < limit);
        if (kick_ack)
            ack_cycles = cycles;
    endtask

    task automatic start_pass(input logic enable_level);
        int ack_cycles;
        load_image();
        kick_and_wait_ack(enable_level, 20, ack_cycles);
        if (ack_cycles == 0)
            report_timeout("kick_ack");
        else
            check(ack_cycles == `NABP_PARTITIONS,
                  $sformatf("kick_ack came %0d cycles after the kick", ack_cycles));
        @(negedge clk);
        check(!image_loaded, "image_loaded still high after kick_ack");
    endtask

    task automatic wait_beats(input int target, input logic random_enable);
        int cycles;
        cycles = 0;
        while (beat_count < target && cycles < wait_limit)
        begin
            @(posedge clk);
            if (random_enable)
                enable <= next_enable();
            cycles++;
        end
        if (beat_count < target)
            report_timeout($sformatf("beat %0d, stream stopped at %0d", target, beat_count));
        enable <= 1'b1;
        // room for stray beats to show up
        repeat (4) @(posedge clk);
    endtask

    always @(negedge clk)
    begin : monitor
        logic [19:0] actual;
        logic [19:0] expected;
        if (enable)
            enable_count++;
        if (out_valid)
        begin
            actual = {out_pixel.data, 1'b0, out_pixel.mode, out_pixel.line_end,
                      out_pixel.pass_end};
            beat_count++;
            check(beat_count <= total_beats && beat_count <= enable_count,
                  $sformatf("beat %0d beyond the stream or the enabled cycles", beat_count));
            if (beat_count <= total_beats)
            begin
                expected = golden_mem[golden_w'(`NABP_PIXELS + beat_count - 1)];
                check(actual == expected,
                      $sformatf("beat %0d is %h, expected %h", beat_count, actual, expected));
                if (actual[2])
                    y_beats++;
                else
                    x_beats++;
                if (actual[0])
                    pass_end_beat = beat_count;
            end
        end
    end

    initial
    begin
        int ack_cycles;
        int errors_before;
        reset_n   = 1'b1;
        in_write  = 1'b0;
        in_data   = '0;
        kick      = 1'b0;
        enable    = 1'b0;
        lcg_state = 32'd93791;
        $readmemh("image_fetch_golden.txt", golden_mem);
        apply_reset();

        errors_before = error_count;
        kick_and_wait_ack(1'b0, 20, ack_cycles);
        check(ack_cycles == 0, "kick_ack without a loaded image");
        start_pass(1'b1);
        report_test("load and kick", errors_before);

        // x0, y0 and x1 are done by beat 96
        errors_before = error_count;
        wait_beats(3 * total_beats / 4, 1'b0);
        check(x_beats == `NABP_PIXELS, $sformatf("%0d x scan beats", x_beats));
        report_test("x scan order", errors_before);

        errors_before = error_count;
        wait_beats(total_beats, 1'b0);
        check(y_beats == `NABP_PIXELS, $sformatf("%0d y scan beats", y_beats));
        check(pass_end_beat == total_beats, $sformatf("pass_end on beat %0d", pass_end_beat));
        report_test("y scan order", errors_before);

        errors_before = error_count;
        start_pass(1'b0);
        wait_beats(total_beats, 1'b1);
        check(beat_count == total_beats && pass_end_beat == total_beats,
              $sformatf("%0d beats, pass_end on beat %0d", beat_count, pass_end_beat));
        report_test("back-pressure", errors_before);

        errors_before = error_count;
        start_pass(1'b1);
        wait_beats(total_beats, 1'b0);
        check(beat_count == total_beats, $sformatf("%0d beats in the second frame", beat_count));
        report_test("second frame", errors_before);

        errors_before = error_count;
        start_pass(1'b1);
        wait_beats(20, 1'b0);
        // reload while the scan runs so that reset has image_loaded to clear
        load_image();
        @(posedge clk);
        apply_reset();
        @(negedge clk);
        check(!out_valid && !kick_ack && !image_loaded, "outputs not cleared by reset");
        kick_and_wait_ack(1'b1, 40, ack_cycles);
        @(posedge clk);
        check(ack_cycles == 0 && beat_count == 0, "activity after reset without a new load");
        start_pass(1'b1);
        wait_beats(total_beats, 1'b0);
        check(beat_count == total_beats, $sformatf("%0d beats after reset", beat_count));
        report_test("reset mid-pass", errors_before);

        $display("%0d tests run, error count %0d", test_count, error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* image_fetch_top.sv */
`timescale 1ns/1ps
`include "nabp_config.svh"

module image_fetch_top
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     in_write,
    input  logic [`NABP_PIXEL_W-1:0] in_data,
    input  logic                     kick,
    input  logic                     enable,
    output logic                     image_loaded,
    output logic                     kick_ack,
    output logic                     out_valid,
    output nabp_pkg::pixel_out_t     out_pixel
);

    nabp_pkg::pixel_write_t   ram_write;
    logic                     ram_write_en;
    logic [`NABP_ADDR_W-1:0]  rd_addr;
    logic [`NABP_PIXEL_W-1:0] rd_data;
    nabp_pkg::ram_read_t      rd_tag;

    image_loader image_loader_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .in_write     (in_write),
        .in_data      (in_data),
        .kick_ack     (kick_ack),
        .ram_write    (ram_write),
        .ram_write_en (ram_write_en),
        .image_loaded (image_loaded)
    );

    image_ram image_ram_i (
        .clk          (clk),
        .ram_write    (ram_write),
        .ram_write_en (ram_write_en),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

    image_addresser image_addresser_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .kick         (kick),
        .image_loaded (image_loaded),
        .enable       (enable),
        .kick_ack     (kick_ack),
        .rd_addr      (rd_addr),
        .rd_tag       (rd_tag)
    );

    pixel_streamer pixel_streamer_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .rd_data   (rd_data),
        .rd_tag    (rd_tag),
        .out_valid (out_valid),
        .out_pixel (out_pixel)
    );

endmodule

/* pixel_streamer.sv */
`timescale 1ns/1ps
`include "nabp_config.svh"

module pixel_streamer
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic [`NABP_PIXEL_W-1:0] rd_data,
    input  nabp_pkg::ram_read_t      rd_tag,
    output logic                     out_valid,
    output nabp_pkg::pixel_out_t     out_pixel
);

    nabp_pkg::ram_read_t tag_q;

    // tag waits out the ram read latency
    always_ff @(posedge clk)
    begin
        if (reset_n)
            tag_q <= '0;
        else
            tag_q <= rd_tag;
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
            out_valid <= 1'b0;
        else
            out_valid <= tag_q.valid;
    end

    // output holds the last pixel between beats
    always_ff @(posedge clk)
    begin
        if (tag_q.valid)
        begin
            out_pixel <= '{
                data:     rd_data,
                mode:     tag_q.mode,
                line_end: tag_q.line_end,
                pass_end: tag_q.pass_end
            };
        end
    end

endmodule

/* image_addresser.sv */
`timescale 1ns/1ps
`include "nabp_config.svh"

module image_addresser
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    kick,
    input  logic                    image_loaded,
    input  logic                    enable,
    output logic                    kick_ack,
    output logic [`NABP_ADDR_W-1:0] rd_addr,
    output nabp_pkg::ram_read_t     rd_tag
);

    localparam logic [`NABP_PART_W-1:0] last_part = `NABP_PART_W'(`NABP_PARTITIONS - 1);
    localparam logic [`NABP_SCAN_W-1:0] last_scan = `NABP_SCAN_W'(`NABP_IMAGE_SIZE - 1);
    localparam logic [`NABP_LINE_W-1:0] last_line = `NABP_LINE_W'(`NABP_PART_SIZE - 1);
    localparam logic [`NABP_ADDR_W-1:0] row_step = `NABP_ADDR_W'(`NABP_IMAGE_SIZE);
    localparam logic [`NABP_ADDR_W-1:0] band_step =
        `NABP_ADDR_W'(`NABP_PART_SIZE * `NABP_IMAGE_SIZE);
    localparam logic [`NABP_ADDR_W-1:0] strip_step = `NABP_ADDR_W'(`NABP_PART_SIZE);

    nabp_pkg::addresser_state_e state;
    nabp_pkg::addresser_state_e next_state;
    nabp_pkg::scan_mode_e       scan_mode;

    logic [`NABP_PART_W-1:0] pe_pos;
    logic [`NABP_SCAN_W-1:0] scan_pos;
    logic [`NABP_LINE_W-1:0] line_pos;
    logic [`NABP_ADDR_W-1:0] base_addr;
    logic [`NABP_ADDR_W-1:0] off_x;
    logic [`NABP_ADDR_W-1:0] off_y;

    logic addressing;
    logic pe_done;
    logic scan_done;
    logic line_done;
    logic delay_done;
    logic part_done;

    assign addressing = (state == nabp_pkg::addressing_x_s) ||
                        (state == nabp_pkg::addressing_y_s);
    assign scan_mode = (state == nabp_pkg::addressing_y_s) ? nabp_pkg::scan_y : nabp_pkg::scan_x;

    assign pe_done   = (pe_pos == last_part);
    assign scan_done = (scan_pos == last_scan);
    assign line_done = (line_pos == last_line);
    // last pixel of the current scan direction
    assign part_done = scan_done && line_done;

    // pe_pos doubles as the delay counter
    assign delay_done = (state == nabp_pkg::delay_s) && pe_done;
    assign kick_ack   = delay_done;

    assign rd_addr = base_addr + ((scan_mode == nabp_pkg::scan_x) ? off_x : off_y);

    assign rd_tag = '{
        mode:     scan_mode,
        line_end: addressing && scan_done,
        pass_end: (state == nabp_pkg::addressing_y_s) && part_done && pe_done,
        valid:    addressing && enable
    };

    // band base steps by one pixel, strip base steps down a column
    always_ff @(posedge clk)
    begin
        if (reset_n)
            base_addr <= '0;
        else if (!addressing)
            base_addr <= '0;
        else if (enable)
        begin
            if (part_done)
                base_addr <= '0;
            else if (state == nabp_pkg::addressing_x_s)
                base_addr <= base_addr + `NABP_ADDR_W'(1);
            else if (scan_done)
                base_addr <= `NABP_ADDR_W'(line_pos) + `NABP_ADDR_W'(1);
            else
                base_addr <= base_addr + row_step;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_n || (state == nabp_pkg::ready_s))
        begin
            pe_pos   <= '0;
            scan_pos <= '0;
            line_pos <= '0;
            off_x    <= '0;
            off_y    <= '0;
        end
        else if (state == nabp_pkg::delay_s)
        begin
            pe_pos <= delay_done ? '0 : pe_pos + `NABP_PART_W'(1);
        end
        else if (enable)
        begin
            scan_pos <= scan_done ? '0 : scan_pos + `NABP_SCAN_W'(1);
            if (scan_done)
                line_pos <= line_done ? '0 : line_pos + `NABP_LINE_W'(1);
            // both scans of a partition done, move to the next band and strip
            if (part_done && (state == nabp_pkg::addressing_y_s))
            begin
                pe_pos <= pe_pos + `NABP_PART_W'(1);
                off_x  <= off_x + band_step;
                off_y  <= off_y + strip_step;
            end
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            nabp_pkg::ready_s:
                if (kick && image_loaded)
                    next_state = nabp_pkg::delay_s;
            nabp_pkg::delay_s:
                if (delay_done)
                    next_state = nabp_pkg::addressing_x_s;
            nabp_pkg::addressing_x_s:
                if (enable && part_done)
                    next_state = nabp_pkg::addressing_y_s;
            nabp_pkg::addressing_y_s:
                if (enable && part_done)
                    next_state = pe_done ? nabp_pkg::ready_s : nabp_pkg::addressing_x_s;
            default:
                next_state = nabp_pkg::ready_s;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
            state <= nabp_pkg::ready_s;
        else
            state <= next_state;
    end

endmodule

/* image_ram.sv */
`timescale 1ns/1ps
`include "nabp_config.svh"

module image_ram
(
    input  logic                     clk,
    input  nabp_pkg::pixel_write_t   ram_write,
    input  logic                     ram_write_en,
    input  logic [`NABP_ADDR_W-1:0]  rd_addr,
    output logic [`NABP_PIXEL_W-1:0] rd_data
);

    logic [`NABP_PIXEL_W-1:0] mem [0:`NABP_PIXELS-1];

    always_ff @(posedge clk)
    begin
        if (ram_write_en)
            mem[ram_write.addr] <= ram_write.data;
    end

    // read every cycle, data one cycle after the address
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* image_loader.sv */
`timescale 1ns/1ps
`include "nabp_config.svh"

module image_loader
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     in_write,
    input  logic [`NABP_PIXEL_W-1:0] in_data,
    input  logic                     kick_ack,
    output nabp_pkg::pixel_write_t   ram_write,
    output logic                     ram_write_en,
    output logic                     image_loaded
);

    localparam logic [`NABP_ADDR_W-1:0] last_addr = `NABP_ADDR_W'(`NABP_PIXELS - 1);

    logic [`NABP_ADDR_W-1:0] wr_addr;
    logic                    accept;

    // a full image blocks further writes until the pass has been kicked
    assign accept = in_write && !image_loaded;

    assign ram_write_en = accept;
    assign ram_write = '{data: in_data, addr: wr_addr};

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            wr_addr      <= '0;
            image_loaded <= 1'b0;
        end
        else if (kick_ack)
        begin
            wr_addr      <= '0;
            image_loaded <= 1'b0;
        end
        else if (accept)
        begin
            // raster order, wraps to zero on the last pixel
            wr_addr <= wr_addr + `NABP_ADDR_W'(1);
            if (wr_addr == last_addr)
                image_loaded <= 1'b1;
        end
    end

endmodule

/* nabp_pkg.sv */
`include "nabp_config.svh"

package nabp_pkg;

    // addresser fsm
    typedef enum logic [1:0] {
        ready_s        = 2'd0,
        delay_s        = 2'd1,
        addressing_x_s = 2'd2,
        addressing_y_s = 2'd3
    } addresser_state_e;

    // row scan or column scan
    typedef enum logic {
        scan_x = 1'b0,
        scan_y = 1'b1
    } scan_mode_e;

    typedef struct packed {
        logic [`NABP_PIXEL_W-1:0] data;
        logic [`NABP_ADDR_W-1:0]  addr;
    } pixel_write_t;

    // travels alongside the read address
    typedef struct packed {
        scan_mode_e mode;
        logic       line_end;
        logic       pass_end;
        logic       valid;
    } ram_read_t;

    typedef struct packed {
        logic [`NABP_PIXEL_W-1:0] data;
        scan_mode_e               mode;
        logic                     line_end;
        logic                     pass_end;
    } pixel_out_t;

endpackage

/* nabp_config.svh */
`ifndef NABP_CONFIG_SVH
`define NABP_CONFIG_SVH

// square image, pixels per row and per column
`define NABP_IMAGE_SIZE 8
// pixels in the whole image
`define NABP_PIXELS (`NABP_IMAGE_SIZE * `NABP_IMAGE_SIZE)

// lines per partition and number of partitions
`define NABP_PART_SIZE 4
`define NABP_PARTITIONS 2

// bus and counter widths
`define NABP_ADDR_W 6
`define NABP_PIXEL_W 16
`define NABP_PART_W 1

// position along one line
`define NABP_SCAN_W 3
// line index inside a partition
`define NABP_LINE_W 2

`endif
